//--- SmartBikeTelemetry.f
common/bikePkg.sv
lights/lightController.sv
rpm/rpmCounter.sv
hdl/telemetryArbiter.sv
hdl/uartTx.sv
hdl/SmartBikeTelemetry.sv
tests/tbSmartBike_assertions.sv
tests/tbSmartBike.sv

//--- Makefile
# Verilator flow for the telemetry project
TOP = tbSmartBike

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f SmartBikeTelemetry.f --top-module SmartBikeTelemetry

sim:
	verilator --binary --timing --assert -f SmartBikeTelemetry.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/tbSmartBike.sv
// Testbench for the telemetry top level: stimulus, UART frame decoder and checks
`timescale 1ns/100ps

module tbSmartBike;
	import bikePkg::*;

	// Window long enough for more than 255 two-cycle blips
	localparam int GateLen = 600;
	localparam int HalfBlink = 16;

	logic		CLOCK_50;
	logic		rstN;
	logic		leftBlinker;
	logic		rightBlinker;
	logic		headLight;
	logic		brakes;
	logic		blips;
	logic		leftBlinkerOut;
	logic		rightBlinkerOut;
	logic		headLightOut;
	logic		brakeLightOut;
	logic		txd;
	logic	[15:0]	lfsr = 16'd11973;
	logic	[3:0]	lastPat = '0;
	logic	[7:0]	lampQ[$];
	logic	[7:0]	speedQ[$];
	// Tags in arrival order
	logic	[7:0]	tagLog[$];
	int			speedFrames = 0;

	SmartBikeTelemetry #(
		.DebounceCycles(4),
		.BlinkHalfPeriod(HalfBlink),
		.GateCycles(GateLen),
		.BitCycles(4)
	) uut (.*);

	initial begin
		CLOCK_50 = 1'b0;
		forever #2 CLOCK_50 = ~CLOCK_50;
	end

	task automatic stopFail(input string line);
		$display("%s", line);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input int expVal, input int gotVal);
		stopFail($sformatf("ERR %s expected %0d actual %0d", name, expVal, gotVal));
	endtask

	// A bound assertion failure ends the run
	always @(posedge CLOCK_50) begin
		if (uut.chk.fails != 0) stopFail("bound protocol assertion failed");
	end

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic int drawBits(input int n);
		logic fb;
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = (r << 1) | fb;
		end
		return r;
	endfunction

	// Switch order matches the lamp-status bits
	task automatic driveSwitches(input logic [3:0] v);
		@(posedge CLOCK_50);
		leftBlinker <= v[lampLeft];
		rightBlinker <= v[lampRight];
		headLight <= v[lampHead];
		brakes <= v[lampBrake];
	endtask

	// Short glitch first, then the new stable pattern
	task automatic applyPattern(input logic [3:0] pat);
		int g;
		g = drawBits(2);
		driveSwitches(lastPat ^ (4'b1 << g));
		driveSwitches(lastPat ^ (4'b1 << g));
		driveSwitches(lastPat);
		repeat (8) @(posedge CLOCK_50);
		if (pat != lastPat) begin
			lampQ.push_back({4'b0, pat});
		end
		lastPat = pat;
		driveSwitches(pat);
	endtask

	task automatic waitLampsSent();
		int t;
		t = 0;
		while (lampQ.size() != 0) begin
			@(negedge CLOCK_50);
			t++;
			if (t > 1000) stopFail("lamp-status frame never arrived");
		end
		assert (headLightOut == lastPat[lampHead])
			else reportMismatch("headLamp", lastPat[lampHead], headLightOut);
		assert (brakeLightOut == lastPat[lampBrake])
			else reportMismatch("brakeLamp", lastPat[lampBrake], brakeLightOut);
	endtask

	// Lights went first, so the tie behind that frame goes to speed
	task automatic checkOrder();
		if (tagLog.size() != 3) stopFail("wrong number of frames around the collision");
		assert (tagLog[0] == tagLights) else reportMismatch("orderFirst", tagLights, tagLog[0]);
		assert (tagLog[1] == tagSpeed) else reportMismatch("orderSecond", tagSpeed, tagLog[1]);
		assert (tagLog[2] == tagLights) else reportMismatch("orderThird", tagLights, tagLog[2]);
	endtask

	function automatic logic blinkOut(input int side);
		return side == lampLeft ? leftBlinkerOut : rightBlinkerOut;
	endfunction

	// Enable one blinker and time its on, off, on phases
	task automatic checkBlinker(input int side);
		int t;
		int n;
		logic lvl;
		applyPattern(4'b1 << side);
		t = 0;
		while (blinkOut(side) !== 1'b1) begin
			@(negedge CLOCK_50);
			t++;
			if (t > 40) stopFail("blinker lamp did not turn on");
		end
		lvl = 1'b1;
		repeat (3) begin
			n = 0;
			while (blinkOut(side) == lvl && n <= 4 * HalfBlink) begin
				n++;
				@(negedge CLOCK_50);
			end
			assert (n == HalfBlink) else reportMismatch("blinkPhase", HalfBlink, n);
			lvl = ~lvl;
		end
		waitLampsSent();
		applyPattern(4'b0000);
		waitLampsSent();
		assert (blinkOut(side) == 1'b0) else reportMismatch("blinkOff", 0, blinkOut(side));
	endtask

	task automatic recvByte(input int idleLimit, output logic [7:0] b);
		int t;
		t = 0;
		@(negedge CLOCK_50);
		while (txd !== 1'b0) begin
			t++;
			if (t > idleLimit) stopFail("UART start bit did not arrive in time");
			@(negedge CLOCK_50);
		end
		// Move to mid-bit
		repeat (2) @(negedge CLOCK_50);
		if (txd !== 1'b0) stopFail("UART start bit too short");
		for (int i = 0; i < 8; i++) begin
			repeat (4) @(negedge CLOCK_50);
			b[i] = txd;
		end
		repeat (4) @(negedge CLOCK_50);
		if (txd !== 1'b1) stopFail("UART stop bit missing");
	endtask

	// Frame decoder, pops the queue picked by the tag
	initial begin
		logic [7:0] tagB;
		logic [7:0] valB;
		logic [7:0] expVal;
		wait (rstN === 1'b1);
		forever begin
			recvByte(3000, tagB);
			recvByte(8, valB);
			tagLog.push_back(tagB);
			if (tagB == tagSpeed) begin
				if (speedQ.size() == 0) stopFail("speed frame arrived with none expected");
				expVal = speedQ.pop_front();
				assert (valB == expVal) else reportMismatch("speedFrame", expVal, valB);
				speedFrames++;
			end else if (tagB == tagLights) begin
				if (lampQ.size() == 0) stopFail("lamp frame arrived with none expected");
				expVal = lampQ.pop_front();
				assert (valB == expVal) else reportMismatch("lampFrame", expVal, valB);
			end else begin
				stopFail("frame with an unknown tag byte");
			end
		end
	end

	// Blip driver, one LFSR count per window, third window saturates
	initial begin
		int n;
		int t;
		int win;
		blips = 1'b0;
		wait (rstN === 1'b1);
		speedQ.push_back(8'd0);
		win = 1;
		forever begin
			t = 0;
			@(negedge CLOCK_50);
			while (uut.rpm.gateEnd !== 1'b1) begin
				t++;
				if (t > GateLen + 10) stopFail("speed window end not seen");
				@(negedge CLOCK_50);
			end
			n = drawBits(8);
			if (win == 2) n = 280;
			speedQ.push_back(n > 255 ? 8'd255 : 8'(n));
			win++;
			repeat (3) @(posedge CLOCK_50);
			repeat (n) begin
				blips <= 1'b1;
				@(posedge CLOCK_50);
				blips <= 1'b0;
				@(posedge CLOCK_50);
			end
		end
	end

	initial begin
		int r;
		int t;
		rstN = 1'b0;
		leftBlinker = 1'b0;
		rightBlinker = 1'b0;
		headLight = 1'b0;
		brakes = 1'b0;
		repeat (8) @(posedge CLOCK_50);
		rstN <= 1'b1;
		// Idle line checked by the bound assertions
		repeat (50) @(posedge CLOCK_50);
		for (int i = 0; i < 6; i++) begin
			r = drawBits(4);
			applyPattern(4'(r));
			waitLampsSent();
		end
		applyPattern(4'b0000);
		waitLampsSent();
		checkBlinker(lampLeft);
		checkBlinker(lampRight);
		// First lamp frame launches just before a window end
		// Second lamp change and the speed result both wait behind it
		repeat (2) begin
			t = 0;
			@(negedge CLOCK_50);
			while (uut.rpm.gateCnt != GateLen - 24) begin
				t++;
				if (t > 2 * GateLen) stopFail("window position for collision not reached");
				@(negedge CLOCK_50);
			end
			tagLog.delete();
			applyPattern(lastPat ^ 4'b0100);
			applyPattern(lastPat ^ 4'b1000);
			waitLampsSent();
			checkOrder();
		end
		t = 0;
		while (speedFrames < 6) begin
			@(negedge CLOCK_50);
			t++;
			if (t > 8 * GateLen) stopFail("too few speed frames arrived");
		end
		if (uut.chk.fails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- tests/tbSmartBike_assertions.sv
// Handshake, transmitter and reset assertions bound into the telemetry top level
`timescale 1ns/100ps

module smartBikeAssertions (
	input	logic			CLOCK_50,
	input	logic			rstN,
	input	logic			txd,
	input	logic			leftBlinkerOut,
	input	logic			rightBlinkerOut,
	input	logic			headLightOut,
	input	logic			brakeLightOut,
	input	logic			lightReq,
	input	logic			lightAck,
	input	logic	[7:0]	lightValue,
	input	logic			speedReq,
	input	logic			speedAck,
	input	logic	[7:0]	speedValue,
	input	logic			start,
	input	logic			busy
);

	// Failed checks, watched by the testbench
	int fails = 0;

	// Reset leaves the line idle and every lamp dark
	resetIdle: assert property (@(posedge CLOCK_50) !rstN |=> txd && !busy && !start &&
		!leftBlinkerOut && !rightBlinkerOut && !headLightOut && !brakeLightOut)
		else begin
			fails++;
			$error("outputs not idle after reset");
		end

	// No frame without a granted request
	startNeedsAck: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		start |-> (lightAck || speedAck)) else begin
			fails++;
			$error("start without a granted request");
		end

	// Transmitter only launched when free, then busy follows
	startWhenFree: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		start |-> !busy) else begin
			fails++;
			$error("start while busy");
		end
	busyAfterStart: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		start |=> busy) else begin
			fails++;
			$error("busy did not follow start");
		end

	// Lamp requester side
	lightHold: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		lightReq && $past(lightReq) |-> $stable(lightValue)) else begin
			fails++;
			$error("lamp value moved");
		end
	lightAckRise: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		$rose(lightAck) |-> lightReq) else begin
			fails++;
			$error("lamp ack without req");
		end
	lightAckFall: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		$fell(lightAck) |-> !$past(lightReq)) else begin
			fails++;
			$error("lamp ack fell before req");
		end

	// Speed requester side
	speedHold: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		speedReq && $past(speedReq) |-> $stable(speedValue)) else begin
			fails++;
			$error("speed value moved");
		end
	speedAckRise: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		$rose(speedAck) |-> speedReq) else begin
			fails++;
			$error("speed ack without req");
		end
	speedAckFall: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		$fell(speedAck) |-> !$past(speedReq)) else begin
			fails++;
			$error("speed ack fell before req");
		end

endmodule

bind SmartBikeTelemetry smartBikeAssertions chk (.*);

//--- hdl/SmartBikeTelemetry.sv
// Telemetry and lighting top level: lamps, wheel speed, arbiter, UART
`timescale 1ns/100ps

module SmartBikeTelemetry #(
	// 10 ms at 50 MHz
	parameter int DebounceCycles = 500_000,
	// About 1.5 Hz blink
	parameter int BlinkHalfPeriod = 16_666_667,
	// One second speed window
	parameter int GateCycles = 50_000_000,
	// 115200 baud
	parameter int BitCycles = 434
) (
	input	logic		CLOCK_50,
	input	logic		rstN,
	input	logic		leftBlinker,
	input	logic		rightBlinker,
	input	logic		headLight,
	input	logic		brakes,
	input	logic		blips,
	output	logic		leftBlinkerOut,
	output	logic		rightBlinkerOut,
	output	logic		headLightOut,
	output	logic		brakeLightOut,
	output	logic		txd
);
	import bikePkg::*;

	// Requester handshakes
	logic						lightReq;
	logic						lightAck;
	logic	[valueWidth-1:0]	lightValue;
	logic						speedReq;
	logic						speedAck;
	logic	[valueWidth-1:0]	speedValue;

	// Arbiter to transmitter
	logic						start;
	logic						busy;
	logic	[tagWidth-1:0]		frameTag;
	logic	[valueWidth-1:0]	frameValue;

	// Lamp switches and lamp-status frames
	lightController #(
		.DebounceCycles(DebounceCycles),
		.BlinkHalfPeriod(BlinkHalfPeriod)
	) lights (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.leftBlinker(leftBlinker),
		.rightBlinker(rightBlinker),
		.headLight(headLight),
		.brakes(brakes),
		.leftBlinkerOut(leftBlinkerOut),
		.rightBlinkerOut(rightBlinkerOut),
		.headLightOut(headLightOut),
		.brakeLightOut(brakeLightOut),
		.req(lightReq),
		.ack(lightAck),
		.value(lightValue)
	);

	// Wheel speed
	rpmCounter #(
		.GateCycles(GateCycles)
	) rpm (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.blips(blips),
		.req(speedReq),
		.ack(speedAck),
		.value(speedValue)
	);

	// Shared transmitter access
	telemetryArbiter arbiter (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.lightReq(lightReq),
		.lightAck(lightAck),
		.lightValue(lightValue),
		.speedReq(speedReq),
		.speedAck(speedAck),
		.speedValue(speedValue),
		.start(start),
		.tag(frameTag),
		.value(frameValue),
		.busy(busy)
	);

	// Phone link
	uartTx #(
		.BitCycles(BitCycles)
	) phoneTx (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.start(start),
		.tag(frameTag),
		.value(frameValue),
		.busy(busy),
		.txd(txd)
	);

endmodule

//--- hdl/uartTx.sv
// Two-byte 8N1 frame serializer with busy flag
`timescale 1ns/100ps

module uartTx #(
	parameter int BitCycles = 4
) (
	input	logic								CLOCK_50,
	input	logic								rstN,
	input	logic								start,
	input	logic	[bikePkg::tagWidth-1:0]		tag,
	input	logic	[bikePkg::valueWidth-1:0]	value,
	output	logic								busy,
	output	logic								txd
);
	import bikePkg::*;

	// Start and stop bit around each byte
	localparam int FrameBits = tagWidth + valueWidth + 4;
	localparam int CntWidth = $clog2(BitCycles + 1);
	localparam int IdxWidth = $clog2(FrameBits);

	logic	[FrameBits-2:0]		shiftReg;
	logic	[CntWidth-1:0]		cycleCnt;
	logic	[IdxWidth-1:0]		bitIdx;
	logic						bitEnd;

	// Last clock of the current bit
	assign bitEnd = (cycleCnt == CntWidth'(BitCycles - 1));

	always_ff @(posedge CLOCK_50) begin
		if (!rstN) begin
			busy <= 1'b0;
			txd <= 1'b1;
			cycleCnt <= '0;
			bitIdx <= '0;
		end else if (!busy) begin
			// Start bit goes straight out
			if (start) begin
				busy <= 1'b1;
				txd <= 1'b0;
				cycleCnt <= '0;
				bitIdx <= '0;
			end
		end else if (bitEnd) begin
			cycleCnt <= '0;
			if (bitIdx == IdxWidth'(FrameBits - 1)) begin
				// Second stop bit done
				busy <= 1'b0;
				txd <= 1'b1;
			end else begin
				bitIdx <= bitIdx + 1'b1;
				txd <= shiftReg[0];
			end
		end else begin
			cycleCnt <= cycleCnt + 1'b1;
		end
	end

	// Rest of the frame after the first start bit, LSB first
	// Ones shift in behind so the line idles high
	always_ff @(posedge CLOCK_50) begin
		if (!busy && start) begin
			shiftReg <= {1'b1, value, 1'b0, 1'b1, tag};
		end else if (busy && bitEnd) begin
			shiftReg <= {1'b1, shiftReg[FrameBits-2:1]};
		end
	end

endmodule

//--- hdl/telemetryArbiter.sv
// Two-requester four-phase arbiter with alternating priority, feeds the UART
`timescale 1ns/100ps

module telemetryArbiter (
	input	logic								CLOCK_50,
	input	logic								rstN,
	input	logic								lightReq,
	output	logic								lightAck,
	input	logic	[bikePkg::valueWidth-1:0]	lightValue,
	input	logic								speedReq,
	output	logic								speedAck,
	input	logic	[bikePkg::valueWidth-1:0]	speedValue,
	output	logic								start,
	output	logic	[bikePkg::tagWidth-1:0]		tag,
	output	logic	[bikePkg::valueWidth-1:0]	value,
	input	logic								busy
);
	import bikePkg::*;

	logic		lightWaiting;
	logic		speedWaiting;
	logic		canStart;
	logic		pickSpeed;
	logic		launch;
	logic		lastSpeed;

	// Open request not yet acknowledged
	assign lightWaiting = lightReq & ~lightAck;
	assign speedWaiting = speedReq & ~speedAck;

	// busy rises one cycle after start, so start itself also blocks
	assign canStart = ~busy & ~start;

	// Speed wins alone, or on a tie when lights went last
	assign pickSpeed = speedWaiting & (~lightWaiting | ~lastSpeed);
	assign launch = canStart & (lightWaiting | speedWaiting);

	always_ff @(posedge CLOCK_50) begin
		if (!rstN) begin
			start <= 1'b0;
			lightAck <= 1'b0;
			speedAck <= 1'b0;
			// Lights first after reset
			lastSpeed <= 1'b1;
		end else begin
			start <= 1'b0;
			// Return to zero once req has dropped
			if (lightAck && !lightReq) begin
				lightAck <= 1'b0;
			end
			if (speedAck && !speedReq) begin
				speedAck <= 1'b0;
			end
			// Ack rises together with start
			if (launch) begin
				start <= 1'b1;
				lastSpeed <= pickSpeed;
				if (pickSpeed) begin
					speedAck <= 1'b1;
				end else begin
					lightAck <= 1'b1;
				end
			end
		end
	end

	// Frame bytes, tag chosen by the port that won
	always_ff @(posedge CLOCK_50) begin
		if (launch) begin
			tag <= pickSpeed ? tagSpeed : tagLights;
			value <= pickSpeed ? speedValue : lightValue;
		end
	end

endmodule

//--- rpm/rpmCounter.sv
// Wheel blip counter over a fixed gate window with speed-frame requester
`timescale 1ns/100ps

module rpmCounter #(
	parameter int GateCycles = 400
) (
	input	logic								CLOCK_50,
	input	logic								rstN,
	input	logic								blips,
	output	logic								req,
	input	logic								ack,
	output	logic	[bikePkg::valueWidth-1:0]	value
);
	import bikePkg::*;

	localparam int GateWidth = $clog2(GateCycles + 1);
	localparam logic [valueWidth-1:0] MaxCount = '1;

	logic	[1:0]				blipSync;
	logic						blipPrev;
	logic						blipEdge;
	logic	[GateWidth-1:0]		gateCnt;
	logic						gateEnd;
	logic	[valueWidth-1:0]	count;
	logic	[valueWidth-1:0]	nextCount;

	// Synchronizer plus one stage for edge detect
	always_ff @(posedge CLOCK_50) begin
		if (!rstN) begin
			blipSync <= '0;
			blipPrev <= 1'b0;
		end else begin
			blipSync <= {blipSync[0], blips};
			blipPrev <= blipSync[1];
		end
	end

	assign blipEdge = blipSync[1] & ~blipPrev;

	// Saturating count, a blip in the last cycle still belongs to this window
	assign nextCount = (blipEdge && count != MaxCount) ? count + 1'b1 : count;
	assign gateEnd = (gateCnt == GateWidth'(GateCycles - 1));

	// Gate window and blip count
	always_ff @(posedge CLOCK_50) begin
		if (!rstN) begin
			gateCnt <= '0;
			count <= '0;
		end else if (gateEnd) begin
			gateCnt <= '0;
			count <= '0;
		end else begin
			gateCnt <= gateCnt + 1'b1;
			count <= nextCount;
		end
	end

	// Requester side
	// Window result dropped while the last handshake is still open
	always_ff @(posedge CLOCK_50) begin
		if (!rstN) begin
			req <= 1'b0;
		end else if (req) begin
			if (ack) begin
				req <= 1'b0;
			end
		end else if (gateEnd && !ack) begin
			req <= 1'b1;
		end
	end

	// Result held while req is high
	always_ff @(posedge CLOCK_50) begin
		if (!req && gateEnd && !ack) begin
			value <= nextCount;
		end
	end

endmodule

//--- lights/lightController.sv
// Switch debouncer, blinker timer, lamp drive and lamp-status requester
`timescale 1ns/100ps

module lightController #(
	parameter int DebounceCycles = 4,
	parameter int BlinkHalfPeriod = 16
) (
	input	logic								CLOCK_50,
	input	logic								rstN,
	input	logic								leftBlinker,
	input	logic								rightBlinker,
	input	logic								headLight,
	input	logic								brakes,
	output	logic								leftBlinkerOut,
	output	logic								rightBlinkerOut,
	output	logic								headLightOut,
	output	logic								brakeLightOut,
	output	logic								req,
	input	logic								ack,
	output	logic	[bikePkg::valueWidth-1:0]	value
);
	import bikePkg::*;

	localparam int NumSw = 4;
	localparam int DbWidth = $clog2(DebounceCycles + 1);
	localparam int BlinkWidth = $clog2(BlinkHalfPeriod + 1);

	logic	[NumSw-1:0]			rawSw;
	logic	[NumSw-1:0]			syncA;
	logic	[NumSw-1:0]			syncB;
	logic	[NumSw-1:0]			dbSw;
	logic	[NumSw-1:0]			accept;
	logic	[DbWidth-1:0]		stableCnt [NumSw];
	logic	[BlinkWidth-1:0]	blinkCnt;
	logic						blinkPhase;
	logic						blinkStart;
	logic	[valueWidth-1:0]	curStatus;

	// Switches ordered by lamp-status bit
	assign rawSw[lampLeft] = leftBlinker;
	assign rawSw[lampRight] = rightBlinker;
	assign rawSw[lampHead] = headLight;
	assign rawSw[lampBrake] = brakes;

	// Two-flop synchronizers
	always_ff @(posedge CLOCK_50) begin
		if (!rstN) begin
			syncA <= '0;
			syncB <= '0;
		end else begin
			syncA <= rawSw;
			syncB <= syncA;
		end
	end

	// New level held for DebounceCycles+1 cycles
	always_comb begin
		for (int i = 0; i < NumSw; i++) begin
			accept[i] = (syncB[i] != dbSw[i]) && (stableCnt[i] == DbWidth'(DebounceCycles));
		end
	end

	// Per-switch stable counters
	// Any glitch back to the old level restarts the count
	always_ff @(posedge CLOCK_50) begin
		if (!rstN) begin
			dbSw <= '0;
			for (int i = 0; i < NumSw; i++) begin
				stableCnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NumSw; i++) begin
				if (syncB[i] == dbSw[i] || accept[i]) begin
					stableCnt[i] <= '0;
				end else begin
					stableCnt[i] <= stableCnt[i] + 1'b1;
				end
				if (accept[i]) begin
					dbSw[i] <= syncB[i];
				end
			end
		end
	end

	// Either blinker just switched on
	assign blinkStart = (accept[lampLeft] & syncB[lampLeft]) |
		(accept[lampRight] & syncB[lampRight]);

	// Shared blink timer, restarts in the on phase
	always_ff @(posedge CLOCK_50) begin
		if (!rstN) begin
			blinkCnt <= '0;
			blinkPhase <= 1'b1;
		end else if (blinkStart || !(dbSw[lampLeft] | dbSw[lampRight])) begin
			blinkCnt <= '0;
			blinkPhase <= 1'b1;
		end else if (blinkCnt == BlinkWidth'(BlinkHalfPeriod - 1)) begin
			blinkCnt <= '0;
			blinkPhase <= ~blinkPhase;
		end else begin
			blinkCnt <= blinkCnt + 1'b1;
		end
	end

	// Lamp drive
	assign leftBlinkerOut = dbSw[lampLeft] & blinkPhase;
	assign rightBlinkerOut = dbSw[lampRight] & blinkPhase;
	assign headLightOut = dbSw[lampHead];
	assign brakeLightOut = dbSw[lampBrake];

	// Status byte, upper bits zero
	assign curStatus = {{(valueWidth - NumSw){1'b0}}, dbSw};

	// Requester side of the handshake
	// value doubles as the last status sent
	always_ff @(posedge CLOCK_50) begin
		if (!rstN) begin
			req <= 1'b0;
			value <= '0;
		end else if (req) begin
			if (ack) begin
				req <= 1'b0;
			end
		end else if (!ack && curStatus != value) begin
			// Capture and hold until ack
			req <= 1'b1;
			value <= curStatus;
		end
	end

endmodule

//--- common/bikePkg.sv
// Frame field widths, frame tag bytes and lamp-status bit positions
package bikePkg;

	// Frame field widths
	localparam int tagWidth = 8;
	localparam int valueWidth = 8;

	// Tag bytes, printable ASCII so a serial terminal shows them
	// 'L' for lamp status
	localparam logic [tagWidth-1:0] tagLights = 8'h4C;
	// 'S' for speed
	localparam logic [tagWidth-1:0] tagSpeed = 8'h53;

	// Lamp-status value bits
	// Each bit is the debounced switch, not the blinking lamp
	// Bits 7 to 4 stay zero
	localparam int lampLeft = 0;
	localparam int lampRight = 1;
	localparam int lampHead = 2;
	localparam int lampBrake = 3;

endpackage
